// ==== Makefile ====
# Verilator build and run for the rename stage.

VERILATOR ?= verilator
TOP       ?= rename_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/arch_pkg.sv ====
`include "rename_defines.svh"
`default_nettype none

package arch_pkg;

  // Architectural register number.
  typedef logic [$clog2(`NUM_AR)-1:0] arch_reg_t;

  // Physical register number.
  typedef logic [$clog2(`NUM_PR)-1:0] phys_reg_t;

  // Slot index into the circular free list.
  typedef logic [$clog2(`NUM_FL)-1:0] fl_idx_t;

endpackage

`default_nettype wire

// ==== logic/free_list.sv ====
`include "rename_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module free_list
  import arch_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     alloc_en,
  input  logic [`RETIRE_WIDTH-1:0] free_en,
  input  phys_reg_t                free_phys0,
  input  phys_reg_t                free_phys1,
  input  logic                     rewind_en,
  input  fl_idx_t                  rewind_idx,
  output phys_reg_t                alloc_phys,
  output fl_idx_t                  tail_idx,
  output logic                     free_available
);

  localparam int CNT_W = $clog2(`NUM_FL) + 1;

  phys_reg_t        slots [`NUM_FL];
  fl_idx_t          head;
  fl_idx_t          tail;
  logic [CNT_W-1:0] count;
  logic [1:0]       num_freed;
  fl_idx_t          head_second;
  fl_idx_t          head_next;
  fl_idx_t          rewind_gap;

  assign alloc_phys     = slots[tail];
  assign tail_idx       = tail;
  assign free_available = (count != '0);

  assign num_freed   = {1'b0, free_en[0]} + {1'b0, free_en[1]};
  // Second freed register lands right after the first, if there was one.
  assign head_second = head + fl_idx_t'(free_en[0]);
  assign head_next   = head + fl_idx_t'(num_freed);
  // Free entries occupy [tail, head); zero gap means full here.
  assign rewind_gap  = head_next - rewind_idx;

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= CNT_W'(`NUM_FL);
      for (int i = 0; i < `NUM_FL; i++) begin
        slots[i] <= phys_reg_t'(`NUM_PR - `NUM_FL + i);
      end
    end else begin
      if (free_en[0]) begin
        slots[head] <= free_phys0;
      end
      if (free_en[1]) begin
        slots[head_second] <= free_phys1;
      end
      head <= head_next;

      if (rewind_en) begin
        // All squashed allocations come back.
        tail  <= rewind_idx;
        count <= (rewind_gap == '0) ? CNT_W'(`NUM_FL) : {1'b0, rewind_gap};
      end else begin
        if (alloc_en) begin
          tail <= tail + 1'b1;
        end
        count <= count + CNT_W'(num_freed) - CNT_W'(alloc_en);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`include "rename_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module map_table
  import arch_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  arch_reg_t                src1,
  input  arch_reg_t                src2,
  input  arch_reg_t                dest,
  input  logic                     write_en,
  input  phys_reg_t                new_phys,
  input  logic [`RETIRE_WIDTH-1:0] commit_en,
  input  arch_reg_t                commit_arch0,
  input  arch_reg_t                commit_arch1,
  input  phys_reg_t                commit_phys0,
  input  phys_reg_t                commit_phys1,
  input  logic                     restore_en,
  output phys_reg_t                src1_phys,
  output phys_reg_t                src2_phys,
  output phys_reg_t                old_phys
);

  phys_reg_t spec_map [`NUM_AR];
  phys_reg_t arch_map [`NUM_AR];

  // Reads see the map before this cycle's write.
  assign src1_phys = (src1 == '0) ? phys_reg_t'(`ZERO_PR) : spec_map[src1];
  assign src2_phys = (src2 == '0) ? phys_reg_t'(`ZERO_PR) : spec_map[src2];
  assign old_phys  = (dest == '0) ? phys_reg_t'(`ZERO_PR) : spec_map[dest];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_AR; i++) begin
        spec_map[i] <= phys_reg_t'(i);
        arch_map[i] <= phys_reg_t'(i);
      end
    end else begin
      // Younger commit is written last.
      if (commit_en[0]) begin
        arch_map[commit_arch0] <= commit_phys0;
      end
      if (commit_en[1]) begin
        arch_map[commit_arch1] <= commit_phys1;
      end

      if (restore_en) begin
        for (int i = 0; i < `NUM_AR; i++) begin
          spec_map[i] <= arch_map[i];
        end
      end else if (write_en) begin
        spec_map[dest] <= new_phys;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`include "rename_defines.svh"
`default_nettype none

package pipe_pkg;

  import arch_pkg::*;

  // Retire-queue slot, also handed out as the instruction tag.
  typedef logic [$clog2(`RQ_DEPTH)-1:0] rq_tag_t;

  // One in-flight instruction.
  typedef struct packed {
    logic      valid;
    logic      complete;
    arch_reg_t arch_dest;
    phys_reg_t new_phys;
    phys_reg_t old_phys;
    // Free-list tail before this instruction allocated.
    fl_idx_t   fl_tail_before;
  } rq_entry_t;

endpackage

`default_nettype wire

// ==== logic/rename_defines.svh ====
`default_nettype none

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural and physical register file sizes.
`define NUM_AR 32
`define NUM_PR 64

// Physical registers not holding an architectural mapping at reset.
`define NUM_FL 32

// In-flight instruction window.
`define RQ_DEPTH 8

`define RETIRE_WIDTH 2

// Hardwired zero register, never allocated or freed.
`define ZERO_PR 0

`endif

`default_nettype wire

// ==== logic/rename_unit.sv ====
`include "rename_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module rename_unit
  import arch_pkg::*;
  import pipe_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch_valid,
  input  arch_reg_t                dispatch_dest,
  input  arch_reg_t                dispatch_src1,
  input  arch_reg_t                dispatch_src2,
  input  logic                     complete_en,
  input  rq_tag_t                  complete_tag,
  input  logic                     flush,
  output logic                     rename_ready,
  output phys_reg_t                dispatch_phys_dest,
  output phys_reg_t                src1_phys,
  output phys_reg_t                src2_phys,
  output phys_reg_t                dispatch_old_phys,
  output rq_tag_t                  dispatch_tag,
  output logic [`RETIRE_WIDTH-1:0] retire_valid,
  output phys_reg_t                retire_phys0,
  output phys_reg_t                retire_phys1
);

  logic                     fire;
  logic                     dest_nonzero;
  logic                     alloc;
  phys_reg_t                alloc_phys;
  fl_idx_t                  tail_idx;
  logic                     free_available;
  logic                     has_space;
  logic [`RETIRE_WIDTH-1:0] free_en;
  phys_reg_t                free_phys0;
  phys_reg_t                free_phys1;
  fl_idx_t                  flush_fl_idx;
  arch_reg_t                retire_arch0;
  arch_reg_t                retire_arch1;

  assign dest_nonzero = (dispatch_dest != '0);
  // A zero destination needs no free register.
  assign rename_ready = has_space && (free_available || !dest_nonzero);
  assign fire         = dispatch_valid && rename_ready;
  assign alloc        = fire && dest_nonzero;

  assign dispatch_phys_dest = dest_nonzero ? alloc_phys : phys_reg_t'(`ZERO_PR);

  free_list u_free_list (
    .clock          (clock),
    .reset          (reset),
    .alloc_en       (alloc),
    .free_en        (free_en),
    .free_phys0     (free_phys0),
    .free_phys1     (free_phys1),
    .rewind_en      (flush),
    .rewind_idx     (flush_fl_idx),
    .alloc_phys     (alloc_phys),
    .tail_idx       (tail_idx),
    .free_available (free_available)
  );

  map_table u_map_table (
    .clock        (clock),
    .reset        (reset),
    .src1         (dispatch_src1),
    .src2         (dispatch_src2),
    .dest         (dispatch_dest),
    .write_en     (alloc),
    .new_phys     (alloc_phys),
    .commit_en    (retire_valid),
    .commit_arch0 (retire_arch0),
    .commit_arch1 (retire_arch1),
    .commit_phys0 (retire_phys0),
    .commit_phys1 (retire_phys1),
    .restore_en   (flush),
    .src1_phys    (src1_phys),
    .src2_phys    (src2_phys),
    .old_phys     (dispatch_old_phys)
  );

  retire_queue u_retire_queue (
    .clock         (clock),
    .reset         (reset),
    .push_en       (fire),
    .push_arch     (dispatch_dest),
    .push_new_phys (dispatch_phys_dest),
    .push_old_phys (dispatch_old_phys),
    .push_fl_idx   (tail_idx),
    .complete_en   (complete_en),
    .complete_tag  (complete_tag),
    .flush         (flush),
    .push_tag      (dispatch_tag),
    .has_space     (has_space),
    .retire_valid  (retire_valid),
    .retire_arch0  (retire_arch0),
    .retire_arch1  (retire_arch1),
    .retire_phys0  (retire_phys0),
    .retire_phys1  (retire_phys1),
    .free_en       (free_en),
    .free_phys0    (free_phys0),
    .free_phys1    (free_phys1),
    .flush_fl_idx  (flush_fl_idx)
  );

endmodule

`default_nettype wire

// ==== logic/retire_queue.sv ====
`include "rename_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module retire_queue
  import arch_pkg::*;
  import pipe_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     push_en,
  input  arch_reg_t                push_arch,
  input  phys_reg_t                push_new_phys,
  input  phys_reg_t                push_old_phys,
  input  fl_idx_t                  push_fl_idx,
  input  logic                     complete_en,
  input  rq_tag_t                  complete_tag,
  input  logic                     flush,
  output rq_tag_t                  push_tag,
  output logic                     has_space,
  output logic [`RETIRE_WIDTH-1:0] retire_valid,
  output arch_reg_t                retire_arch0,
  output arch_reg_t                retire_arch1,
  output phys_reg_t                retire_phys0,
  output phys_reg_t                retire_phys1,
  output logic [`RETIRE_WIDTH-1:0] free_en,
  output phys_reg_t                free_phys0,
  output phys_reg_t                free_phys1,
  output fl_idx_t                  flush_fl_idx
);

  rq_entry_t  entries [`RQ_DEPTH];
  rq_tag_t    head;
  rq_tag_t    tail;
  rq_tag_t    head_second;
  rq_entry_t  head_entry;
  rq_entry_t  second_entry;
  logic [1:0] num_retired;

  assign head_second  = head + 1'b1;
  assign head_entry   = entries[head];
  assign second_entry = entries[head_second];

  assign push_tag  = tail;
  assign has_space = !entries[tail].valid;

  // In order only, and nothing retires under a flush.
  assign retire_valid[0] = !flush && head_entry.valid && head_entry.complete;
  assign retire_valid[1] = retire_valid[0] && second_entry.valid && second_entry.complete;
  assign num_retired     = {1'b0, retire_valid[0]} + {1'b0, retire_valid[1]};

  assign retire_arch0 = head_entry.arch_dest;
  assign retire_arch1 = second_entry.arch_dest;
  assign retire_phys0 = head_entry.new_phys;
  assign retire_phys1 = second_entry.new_phys;

  // Old mapping of x0 is never returned.
  assign free_en[0] = retire_valid[0] && (head_entry.old_phys != phys_reg_t'(`ZERO_PR));
  assign free_en[1] = retire_valid[1] && (second_entry.old_phys != phys_reg_t'(`ZERO_PR));
  assign free_phys0 = head_entry.old_phys;
  assign free_phys1 = second_entry.old_phys;

  // Empty queue means nothing to rewind past.
  assign flush_fl_idx = head_entry.valid ? head_entry.fl_tail_before : push_fl_idx;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < `RQ_DEPTH; i++) begin
        entries[i].valid    <= 1'b0;
        entries[i].complete <= 1'b0;
      end
    end else begin
      if (complete_en) begin
        entries[complete_tag].complete <= 1'b1;
      end
      if (retire_valid[0]) begin
        entries[head].valid <= 1'b0;
      end
      if (retire_valid[1]) begin
        entries[head_second].valid <= 1'b0;
      end
      head <= head + rq_tag_t'(num_retired);

      if (push_en) begin
        entries[tail] <= '{valid: 1'b1, complete: 1'b0, arch_dest: push_arch,
                           new_phys: push_new_phys, old_phys: push_old_phys,
                           fl_tail_before: push_fl_idx};
        tail <= tail + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/arch_pkg.sv
logic/pipe_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/retire_queue.sv
logic/rename_unit.sv
test/rename_unit_sva.sv
test/rename_unit_tb.sv

// ==== test/rename_unit_sva.sv ====
`include "rename_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module rename_unit_sva
  import arch_pkg::*;
  import pipe_pkg::*;
(
  input logic                     clock,
  input logic                     reset,
  input logic                     dispatch_valid,
  input arch_reg_t                dispatch_dest,
  input logic                     flush,
  input logic                     rename_ready,
  input phys_reg_t                dispatch_phys_dest,
  input rq_tag_t                  dispatch_tag,
  input logic [`RETIRE_WIDTH-1:0] retire_valid
);

  // Reset leaves an empty window that accepts work.
  assert property (@(posedge clock) reset |=> (rename_ready && retire_valid == '0))
    else $error("rename_ready or retire_valid not at reset value after reset");

  // A stalled dispatch takes no queue slot.
  assert property (@(posedge clock) disable iff (reset)
    (dispatch_valid && !rename_ready && !flush) |=> $stable(dispatch_tag))
    else $error("dispatch_tag moved while dispatch was back-pressured");

  assert property (@(posedge clock) disable iff (reset)
    rename_ready |-> ((dispatch_phys_dest == '0) == (dispatch_dest == '0)))
    else $error("dispatch_phys_dest zero does not match dispatch_dest zero");

endmodule

bind rename_unit rename_unit_sva u_rename_unit_sva (
  .clock              (clock),
  .reset              (reset),
  .dispatch_valid     (dispatch_valid),
  .dispatch_dest      (dispatch_dest),
  .flush              (flush),
  .rename_ready       (rename_ready),
  .dispatch_phys_dest (dispatch_phys_dest),
  .dispatch_tag       (dispatch_tag),
  .retire_valid       (retire_valid)
);

`default_nettype wire

// ==== test/rename_unit_tb.sv ====
`include "rename_defines.svh"
`default_nettype none
`timescale 1ns/1ps

module rename_unit_tb
  import arch_pkg::*;
  import pipe_pkg::*;
();

  localparam int OP_DISP   = 1;
  localparam int OP_CMPL   = 2;
  localparam int OP_RAND   = 4;
  localparam int DONT_CARE = -1;

  // One row per clock cycle.
  typedef struct {
    int        op;
    arch_reg_t dest;
    arch_reg_t src1;
    arch_reg_t src2;
    rq_tag_t   tag;
    logic      flush;
    int        exp_ready;
  } row_t;

  logic                     clock;
  logic                     reset;
  logic                     dispatch_valid;
  arch_reg_t                dispatch_dest;
  arch_reg_t                dispatch_src1;
  arch_reg_t                dispatch_src2;
  logic                     complete_en;
  rq_tag_t                  complete_tag;
  logic                     flush;
  logic                     rename_ready;
  phys_reg_t                dispatch_phys_dest;
  phys_reg_t                src1_phys;
  phys_reg_t                src2_phys;
  phys_reg_t                dispatch_old_phys;
  rq_tag_t                  dispatch_tag;
  logic [`RETIRE_WIDTH-1:0] retire_valid;
  phys_reg_t                retire_phys0;
  phys_reg_t                retire_phys1;

  row_t      rows [$];
  // Reference model state.
  phys_reg_t free_fifo [$];
  phys_reg_t spec_model [`NUM_AR];
  phys_reg_t arch_model [`NUM_AR];
  rq_entry_t window [$];
  rq_tag_t   window_tags [$];
  rq_tag_t   next_tag;
  int        errors;
  int        checks;
  int        cycles;
  int        limit;

  rename_unit UUT (.*);

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic add_row(input int op, input int dest, input int src1, input int src2,
                         input int tag, input logic flush_row, input int exp_ready);
    row_t r;
    r.op        = op;
    r.dest      = arch_reg_t'(dest);
    r.src1      = arch_reg_t'(src1);
    r.src2      = arch_reg_t'(src2);
    r.tag       = rq_tag_t'(tag);
    r.flush     = flush_row;
    r.exp_ready = exp_ready;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Fresh allocations, forwarding and a zero destination.
    add_row(OP_DISP, 1, 0, 0, 0, 1'b0, 1);
    add_row(OP_DISP, 2, 1, 0, 0, 1'b0, 1);
    add_row(OP_DISP, 3, 2, 1, 0, 1'b0, 1);
    add_row(OP_DISP, 0, 3, 3, 0, 1'b0, 1);
    add_row(OP_DISP, 4, 3, 0, 0, 1'b0, 1);
    // Out-of-order completion.
    add_row(OP_CMPL, 0, 0, 0, 2, 1'b0, 1);
    add_row(OP_CMPL, 0, 0, 0, 1, 1'b0, 1);
    add_row(OP_CMPL, 0, 0, 0, 0, 1'b0, 1);
    add_row(0, 0, 0, 0, 0, 1'b0, 1);
    add_row(0, 0, 0, 0, 0, 1'b0, 1);
    add_row(OP_CMPL, 0, 0, 0, 4, 1'b0, 1);
    add_row(OP_CMPL, 0, 0, 0, 3, 1'b0, 1);
    add_row(0, 0, 0, 0, 0, 1'b0, 1);
    // Enough allocations to wrap the free list.
    for (int i = 0; i < 40; i++) begin
      add_row(OP_DISP | OP_RAND, 1 + (i * 7) % 31, (i * 3) % 32, (i * 5) % 32, 0, 1'b0,
              DONT_CARE);
      add_row(OP_RAND, 0, 0, 0, 0, 1'b0, DONT_CARE);
    end
    for (int i = 0; i < 4; i++) begin
      add_row(OP_RAND, 0, 0, 0, 0, 1'b0, DONT_CARE);
    end
    add_row(OP_DISP, 6, 6, 7, 0, 1'b0, 1);
    add_row(OP_DISP, 7, 6, 0, 0, 1'b0, 1);
    add_row(OP_DISP, 0, 7, 6, 0, 1'b0, 1);
    add_row(0, 0, 0, 0, 0, 1'b1, 1);
    add_row(OP_DISP, 6, 6, 7, 0, 1'b0, 1);
    // Fill the window, then hold a dispatch until a slot frees.
    for (int i = 1; i < 8; i++) begin
      add_row(OP_DISP, i, i, 0, 0, 1'b0, 1);
    end
    add_row(OP_DISP | OP_CMPL, 9, 1, 2, 0, 1'b0, 0);
    add_row(OP_DISP, 9, 1, 2, 0, 1'b0, 0);
    add_row(OP_DISP, 9, 1, 2, 0, 1'b0, 1);
    for (int i = 0; i < 12; i++) begin
      add_row(OP_RAND, 0, 0, 0, 0, 1'b0, DONT_CARE);
    end
    for (int i = 0; i < 3; i++) begin
      add_row(0, 0, 0, 0, 0, 1'b0, 1);
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
    errors++;
    $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, expected);
  endtask

  function automatic int pick_incomplete();
    int idx [$];
    foreach (window[i]) begin
      if (!window[i].complete) begin
        idx.push_back(i);
      end
    end
    if (idx.size() == 0) begin
      return -1;
    end
    return idx[$urandom % idx.size()];
  endfunction

  // Moves the model to the state after the coming edge.
  task automatic step_model(input logic flush_row, input logic fire,
                            input logic [1:0] retiring, input phys_reg_t new_phys);
    rq_entry_t e;
    if (flush_row) begin
      // Squashed allocations go back to the front, oldest first.
      for (int i = window.size() - 1; i >= 0; i--) begin
        if (window[i].arch_dest != '0) begin
          free_fifo.push_front(window[i].new_phys);
        end
      end
      spec_model = arch_model;
      window.delete();
      window_tags.delete();
      next_tag = '0;
    end else begin
      if (complete_en) begin
        foreach (window_tags[i]) begin
          if (window_tags[i] == complete_tag) begin
            window[i].complete = 1'b1;
          end
        end
      end
      for (int k = 0; k < `RETIRE_WIDTH; k++) begin
        if (retiring[k]) begin
          arch_model[window[0].arch_dest] = window[0].new_phys;
          if (window[0].old_phys != '0) begin
            free_fifo.push_back(window[0].old_phys);
          end
          void'(window.pop_front());
          void'(window_tags.pop_front());
        end
      end
      if (fire) begin
        e = '{valid: 1'b1, complete: 1'b0, arch_dest: dispatch_dest, new_phys: new_phys,
              old_phys: spec_model[dispatch_dest], fl_tail_before: '0};
        if (dispatch_dest != '0) begin
          void'(free_fifo.pop_front());
          spec_model[dispatch_dest] = new_phys;
        end
        window.push_back(e);
        window_tags.push_back(next_tag);
        next_tag = next_tag + 1'b1;
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    int         pick;
    logic       exp_ready;
    logic       fire;
    logic [1:0] exp_retire;
    phys_reg_t  exp_dest;
    exp_dest = '0;
    @(posedge clock);
    #1;
    dispatch_valid = ((r.op & OP_DISP) != 0);
    dispatch_dest  = r.dest;
    dispatch_src1  = r.src1;
    dispatch_src2  = r.src2;
    complete_en    = ((r.op & OP_CMPL) != 0);
    complete_tag   = r.tag;
    flush          = r.flush;
    if ((r.op & OP_RAND) != 0) begin
      pick = pick_incomplete();
      if (pick >= 0) begin
        complete_en  = 1'b1;
        complete_tag = window_tags[pick];
      end
    end

    @(negedge clock);
    exp_ready     = (window.size() < `RQ_DEPTH) && (free_fifo.size() > 0 || r.dest == '0);
    fire          = dispatch_valid && exp_ready && !r.flush;
    exp_retire[0] = !r.flush && window.size() > 0 && window[0].complete;
    exp_retire[1] = exp_retire[0] && window.size() > 1 && window[1].complete;
    checks++;
    if (rename_ready !== exp_ready) begin
      report_mismatch("rename_ready", 32'(rename_ready), 32'(exp_ready));
    end
    if (r.exp_ready != DONT_CARE && rename_ready !== r.exp_ready[0]) begin
      report_mismatch("rename_ready vs table", 32'(rename_ready), 32'(r.exp_ready));
    end
    if (retire_valid !== exp_retire) begin
      report_mismatch("retire_valid", 32'(retire_valid), 32'(exp_retire));
    end
    if (exp_retire[0] && retire_phys0 !== window[0].new_phys) begin
      report_mismatch("retire_phys0", 32'(retire_phys0), 32'(window[0].new_phys));
    end
    if (exp_retire[1] && retire_phys1 !== window[1].new_phys) begin
      report_mismatch("retire_phys1", 32'(retire_phys1), 32'(window[1].new_phys));
    end
    if (fire) begin
      exp_dest = (r.dest == '0) ? phys_reg_t'(`ZERO_PR) : free_fifo[0];
      if (dispatch_phys_dest !== exp_dest) begin
        report_mismatch("dispatch_phys_dest", 32'(dispatch_phys_dest), 32'(exp_dest));
      end
      if (dispatch_old_phys !== spec_model[r.dest]) begin
        report_mismatch("dispatch_old_phys", 32'(dispatch_old_phys),
                        32'(spec_model[r.dest]));
      end
      if (src1_phys !== spec_model[r.src1]) begin
        report_mismatch("src1_phys", 32'(src1_phys), 32'(spec_model[r.src1]));
      end
      if (src2_phys !== spec_model[r.src2]) begin
        report_mismatch("src2_phys", 32'(src2_phys), 32'(spec_model[r.src2]));
      end
      if (dispatch_tag !== next_tag) begin
        report_mismatch("dispatch_tag", 32'(dispatch_tag), 32'(next_tag));
      end
    end
    step_model(r.flush, fire, exp_retire, exp_dest);
  endtask

  initial begin
    void'($urandom(32'hdf00376c));
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_src1  = '0;
    dispatch_src2  = '0;
    complete_en    = 1'b0;
    complete_tag   = '0;
    flush          = 1'b0;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    next_tag       = '0;
    // Identity maps and registers 32 to 63 free after reset.
    foreach (spec_model[i]) begin
      spec_model[i] = phys_reg_t'(i);
      arch_model[i] = phys_reg_t'(i);
    end
    for (int i = 0; i < `NUM_FL; i++) begin
      free_fifo.push_back(phys_reg_t'(`NUM_PR - `NUM_FL + i));
    end
    build_table();
    limit = rows.size() * 4 + 100;

    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    $display("Checked %0d cycles, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
